// File: mem_pipe_settings.svh
`ifndef MEM_PIPE_SETTINGS_SVH
`define MEM_PIPE_SETTINGS_SVH

// width of registers and of the data bus.
`define MEM_PIPE_DATA_W 32

// byte address width seen by the memory stages.
`define MEM_PIPE_ADDR_W 12

// number of words in the backing array.
`define MEM_PIPE_DEPTH 1024

// words held by the single cache line.
`define MEM_PIPE_LINE_WORDS 4

// cycles spent refilling the line on a miss.
`define MEM_PIPE_MISS_CYCLES 3

`endif

// File: mem_pipe_pkg.sv
`include "mem_pipe_settings.svh"

package mem_pipe_pkg;

    typedef enum logic [3:0] {
        OP_ALU   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_H  = 4'd2,
        OP_LD_W  = 4'd3,
        OP_LD_BU = 4'd4,
        OP_LD_HU = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8
    } mem_op_e;

    typedef enum logic {
        CACHE_IDLE,
        CACHE_REFILL
    } cache_state_e;

    // wdata carries the execute result, or the store data for stores.
    typedef struct packed {
        logic                        valid;
        mem_op_e                     op;
        logic                        wreg;
        logic [4:0]                  waddr;
        logic [`MEM_PIPE_DATA_W-1:0] wdata;
        logic [`MEM_PIPE_DATA_W-1:0] base;
        logic [`MEM_PIPE_DATA_W-1:0] offset;
    } exe_mem_t;

    typedef struct packed {
        logic                        valid;
        logic                        write;
        logic [`MEM_PIPE_ADDR_W-1:0] addr;
        logic [3:0]                  wstrb;
        logic [`MEM_PIPE_DATA_W-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic                        valid;
        mem_op_e                     op;
        logic                        wreg;
        logic [4:0]                  waddr;
        logic [`MEM_PIPE_DATA_W-1:0] wdata;
        logic [`MEM_PIPE_ADDR_W-1:0] mem_addr;
        logic                        mem_access_valid;
    } mem1_mem2_t;

    typedef struct packed {
        logic                        valid;
        logic                        wreg;
        logic [4:0]                  waddr;
        logic [`MEM_PIPE_DATA_W-1:0] wdata;
    } mem2_wb_t;

    typedef struct packed {
        logic                        wreg;
        logic                        valid;
        logic [4:0]                  waddr;
        logic [`MEM_PIPE_DATA_W-1:0] wdata;
    } data_forward_t;

    function automatic logic op_is_load(mem_op_e op);
        return op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

endpackage

// File: mem1_stage.sv
`include "mem_pipe_settings.svh"

module mem1_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush_i,
    input  mem_pipe_pkg::exe_mem_t   exe_i,
    input  logic                     advance_ready_i,
    output logic                     advance_o,
    output mem_pipe_pkg::dcache_req_t req_o,
    output mem_pipe_pkg::mem1_mem2_t mem1_o
);

    mem_pipe_pkg::exe_mem_t   mem1_q;
    mem_pipe_pkg::mem1_mem2_t mem1_mem2_q;
    mem_pipe_pkg::mem1_mem2_t mem1_mem2_d;

    logic                        run_q;
    logic                        advance;
    logic                        is_load;
    logic                        is_store;
    logic                        aligned;
    logic [`MEM_PIPE_DATA_W-1:0] eff_addr;
    logic [`MEM_PIPE_ADDR_W-1:0] mem_addr;
    logic [4:0]                  lane_shift;
    logic [3:0]                  wstrb;
    logic [`MEM_PIPE_DATA_W-1:0] store_data;

    // the pipe stays still for the first cycle out of reset.
    assign advance   = advance_ready_i & run_q;
    assign advance_o = advance;

    assign is_load    = mem_pipe_pkg::op_is_load(mem1_q.op);
    assign is_store   = mem_pipe_pkg::op_is_store(mem1_q.op);
    assign eff_addr   = mem1_q.base + mem1_q.offset;
    assign mem_addr   = eff_addr[`MEM_PIPE_ADDR_W-1:0];
    assign lane_shift = {mem_addr[1:0], 3'b000};

    always_comb begin
        aligned    = 1'b1;
        wstrb      = 4'b0000;
        store_data = '0;
        case (mem1_q.op)
            mem_pipe_pkg::OP_LD_H, mem_pipe_pkg::OP_LD_HU: begin
                aligned = ~mem_addr[0];
            end
            mem_pipe_pkg::OP_LD_W: begin
                aligned = (mem_addr[1:0] == 2'b00);
            end
            mem_pipe_pkg::OP_ST_B: begin
                wstrb      = 4'b0001 << mem_addr[1:0];
                store_data = {24'b0, mem1_q.wdata[7:0]} << lane_shift;
            end
            mem_pipe_pkg::OP_ST_H: begin
                aligned    = ~mem_addr[0];
                wstrb      = 4'b0011 << {mem_addr[1], 1'b0};
                store_data = {16'b0, mem1_q.wdata[15:0]} << lane_shift;
            end
            mem_pipe_pkg::OP_ST_W: begin
                aligned    = (mem_addr[1:0] == 2'b00);
                wstrb      = 4'b1111;
                store_data = mem1_q.wdata;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        mem1_mem2_d.valid            = mem1_q.valid;
        mem1_mem2_d.op               = mem1_q.op;
        mem1_mem2_d.wreg             = mem1_q.wreg;
        mem1_mem2_d.waddr            = mem1_q.waddr;
        mem1_mem2_d.wdata            = mem1_q.wdata;
        mem1_mem2_d.mem_addr         = mem_addr;
        mem1_mem2_d.mem_access_valid = (is_load | is_store) & aligned;
    end

    // a request goes out only in the cycle its op moves into mem2.
    always_comb begin
        req_o.valid = advance & ~flush_i & mem1_q.valid & mem1_mem2_d.mem_access_valid;
        req_o.write = is_store;
        req_o.addr  = mem_addr;
        req_o.wstrb = wstrb;
        req_o.wdata = store_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q       <= 1'b0;
            mem1_q      <= '0;
            mem1_mem2_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (flush_i) begin
                mem1_q      <= '0;
                mem1_mem2_q <= '0;
            end else if (advance) begin
                mem1_q      <= exe_i;
                mem1_mem2_q <= mem1_mem2_d;
            end
        end
    end

    assign mem1_o = mem1_mem2_q;

endmodule

// File: load_data_cache.sv
`include "mem_pipe_settings.svh"

module load_data_cache (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pipe_pkg::dcache_req_t   req_i,
    output logic                        data_ok_o,
    output logic [`MEM_PIPE_DATA_W-1:0] rdata_o
);

    localparam int WORD_W = `MEM_PIPE_ADDR_W - 2;
    localparam int IDX_W  = $clog2(`MEM_PIPE_LINE_WORDS);
    localparam int TAG_W  = WORD_W - IDX_W;
    localparam int CNT_W  = $clog2(`MEM_PIPE_MISS_CYCLES + 1);

    mem_pipe_pkg::cache_state_e state_q;

    logic [CNT_W-1:0]            cnt_q;
    logic [TAG_W-1:0]            tag_q;
    logic                        tag_valid_q;
    logic                        data_ok_q;
    logic [`MEM_PIPE_DATA_W-1:0] rdata_q;
    logic [WORD_W-1:0]           miss_addr_q;
    logic [`MEM_PIPE_DATA_W-1:0] line_q [`MEM_PIPE_LINE_WORDS];
    logic [`MEM_PIPE_DATA_W-1:0] mem_q  [`MEM_PIPE_DEPTH];

    logic [WORD_W-1:0] word_addr;
    logic [TAG_W-1:0]  req_tag;
    logic [IDX_W-1:0]  req_idx;
    logic              accept;
    logic              hit;
    logic              refill_done;

    assign word_addr   = req_i.addr[`MEM_PIPE_ADDR_W-1:2];
    assign req_tag     = word_addr[WORD_W-1:IDX_W];
    assign req_idx     = word_addr[IDX_W-1:0];
    assign accept      = req_i.valid & (state_q == mem_pipe_pkg::CACHE_IDLE);
    assign hit         = tag_valid_q & (tag_q == req_tag);
    assign refill_done = (state_q == mem_pipe_pkg::CACHE_REFILL) & (cnt_q == '0);

    // the backing store comes up cleared.
    initial begin
        for (int i = 0; i < `MEM_PIPE_DEPTH; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= mem_pipe_pkg::CACHE_IDLE;
            cnt_q       <= '0;
            tag_valid_q <= 1'b0;
            data_ok_q   <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state_q)
                mem_pipe_pkg::CACHE_IDLE: begin
                    if (accept & ~req_i.write) begin
                        if (hit) begin
                            data_ok_q <= 1'b1;
                        end else begin
                            state_q <= mem_pipe_pkg::CACHE_REFILL;
                            cnt_q   <= CNT_W'(`MEM_PIPE_MISS_CYCLES - 1);
                        end
                    end
                end
                mem_pipe_pkg::CACHE_REFILL: begin
                    if (refill_done) begin
                        state_q     <= mem_pipe_pkg::CACHE_IDLE;
                        tag_valid_q <= 1'b1;
                        data_ok_q   <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= mem_pipe_pkg::CACHE_IDLE;
                end
            endcase
        end
    end

    // line contents and the read word. Stores hit the line only on a tag match.
    always_ff @(posedge clk) begin
        if (accept & ~req_i.write) begin
            miss_addr_q <= word_addr;
            rdata_q     <= line_q[req_idx];
        end
        if (refill_done) begin
            tag_q   <= miss_addr_q[WORD_W-1:IDX_W];
            rdata_q <= mem_q[miss_addr_q];
            for (int i = 0; i < `MEM_PIPE_LINE_WORDS; i++) begin
                line_q[i] <= mem_q[{miss_addr_q[WORD_W-1:IDX_W], IDX_W'(i)}];
            end
        end
        if (accept & req_i.write & hit) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.wstrb[b]) begin
                    line_q[req_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (accept & req_i.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.wstrb[b]) begin
                    mem_q[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign data_ok_o = data_ok_q;
    assign rdata_o   = rdata_q;

endmodule

// File: mem2_stage.sv
`include "mem_pipe_settings.svh"

module mem2_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush_i,
    input  logic                          advance_i,
    output logic                          advance_ready_o,
    input  mem_pipe_pkg::mem1_mem2_t      mem1_i,
    input  logic                          data_ok_i,
    input  logic [`MEM_PIPE_DATA_W-1:0]   cache_data_i,
    output mem_pipe_pkg::data_forward_t   data_forward_o,
    output mem_pipe_pkg::mem2_wb_t        wb_o
);

    mem_pipe_pkg::mem2_wb_t wb_d;
    mem_pipe_pkg::mem2_wb_t wb_q;

    logic                        is_load;
    logic                        load_pending;
    logic                        got_data;
    logic                        data_already_ok;
    logic                        drain_q;
    logic [`MEM_PIPE_DATA_W-1:0] cache_data_delay;
    logic [`MEM_PIPE_DATA_W-1:0] cache_data;
    logic [`MEM_PIPE_DATA_W-1:0] load_data;
    logic [`MEM_PIPE_DATA_W-1:0] result;
    logic [7:0]                  lane_byte;
    logic [15:0]                 lane_half;

    assign is_load      = mem_pipe_pkg::op_is_load(mem1_i.op);
    assign load_pending = mem1_i.valid & is_load & mem1_i.mem_access_valid;
    assign got_data     = data_ok_i | data_already_ok;

    // drain_q marks a flushed miss that is still refilling. The cache
    // cannot take a new request until its data_ok shows up.
    assign advance_ready_o = drain_q ? data_ok_i : (~load_pending | got_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            drain_q <= 1'b0;
        end else if (data_ok_i) begin
            drain_q <= 1'b0;
        end else if (flush_i & load_pending & ~data_already_ok) begin
            drain_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_already_ok <= 1'b0;
        end else if (advance_i | flush_i) begin
            data_already_ok <= 1'b0;
        end else if (data_ok_i & ~drain_q) begin
            data_already_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok_i) begin
            cache_data_delay <= cache_data_i;
        end
    end

    assign cache_data = data_already_ok ? cache_data_delay : cache_data_i;

    always_comb begin
        case (mem1_i.mem_addr[1:0])
            2'b00:   lane_byte = cache_data[7:0];
            2'b01:   lane_byte = cache_data[15:8];
            2'b10:   lane_byte = cache_data[23:16];
            default: lane_byte = cache_data[31:24];
        endcase
    end

    assign lane_half = mem1_i.mem_addr[1] ? cache_data[31:16] : cache_data[15:0];

    // halfwords at an odd lane come back as zero.
    always_comb begin
        case (mem1_i.op)
            mem_pipe_pkg::OP_LD_B: begin
                load_data = {{(`MEM_PIPE_DATA_W-8){lane_byte[7]}}, lane_byte};
            end
            mem_pipe_pkg::OP_LD_BU: begin
                load_data = {{(`MEM_PIPE_DATA_W-8){1'b0}}, lane_byte};
            end
            mem_pipe_pkg::OP_LD_H: begin
                if (mem1_i.mem_addr[0]) begin
                    load_data = '0;
                end else begin
                    load_data = {{(`MEM_PIPE_DATA_W-16){lane_half[15]}}, lane_half};
                end
            end
            mem_pipe_pkg::OP_LD_HU: begin
                if (mem1_i.mem_addr[0]) begin
                    load_data = '0;
                end else begin
                    load_data = {{(`MEM_PIPE_DATA_W-16){1'b0}}, lane_half};
                end
            end
            mem_pipe_pkg::OP_LD_W: begin
                load_data = cache_data;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    // a misaligned load never reached the cache, so it returns zero.
    always_comb begin
        if (is_load) begin
            result = mem1_i.mem_access_valid ? load_data : '0;
        end else begin
            result = mem1_i.wdata;
        end
    end

    always_comb begin
        wb_d.valid = mem1_i.valid;
        wb_d.wreg  = mem1_i.wreg;
        wb_d.waddr = mem1_i.waddr;
        wb_d.wdata = result;
    end

    always_comb begin
        if (~load_pending | got_data) begin
            data_forward_o.wreg  = mem1_i.wreg;
            data_forward_o.valid = 1'b1;
            data_forward_o.waddr = mem1_i.waddr;
            data_forward_o.wdata = result;
        end else begin
            data_forward_o = '0;
        end
    end

    // valid lasts one cycle per op even when the next advance is late.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q <= '0;
        end else if (flush_i) begin
            wb_q <= '0;
        end else if (advance_i) begin
            wb_q <= wb_d;
        end else begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: mem_pipe_top.sv
`include "mem_pipe_settings.svh"

module mem_pipe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  mem_pipe_pkg::exe_mem_t      exe_i,
    output logic                        advance_o,
    output mem_pipe_pkg::data_forward_t data_forward_o,
    output mem_pipe_pkg::mem2_wb_t      wb_o
);

    mem_pipe_pkg::dcache_req_t   req;
    mem_pipe_pkg::mem1_mem2_t    mem1_mem2;
    logic                        advance_ready;
    logic                        data_ok;
    logic [`MEM_PIPE_DATA_W-1:0] rdata;

    mem1_stage u_mem1 (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .exe_i           (exe_i),
        .advance_ready_i (advance_ready),
        .advance_o       (advance_o),
        .req_o           (req),
        .mem1_o          (mem1_mem2)
    );

    load_data_cache u_dcache (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req),
        .data_ok_o (data_ok),
        .rdata_o   (rdata)
    );

    mem2_stage u_mem2 (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .advance_i       (advance_o),
        .advance_ready_o (advance_ready),
        .mem1_i          (mem1_mem2),
        .data_ok_i       (data_ok),
        .cache_data_i    (rdata),
        .data_forward_o  (data_forward_o),
        .wb_o            (wb_o)
    );

endmodule

// File: mem_pipe_props.sv
module mem_pipe_props (
    input logic clk,
    input logic rst,
    input logic flush_i,
    input logic data_ok_i,
    input logic req_valid_i,
    input logic refill_i,
    input logic load_pending_i,
    input logic drain_i,
    input logic adv_ready_i,
    input logic wb_valid_i
);

    // a hit needs a request in the cycle before its data_ok.
    assert property (@(posedge clk) disable iff (rst) data_ok_i && !req_valid_i |=> !data_ok_i)
        else $error("data_ok high in two cycles without a new request");

    assert property (@(posedge clk) disable iff (rst)
                     !load_pending_i && !drain_i |-> adv_ready_i)
        else $error("advance_ready low while no load is held");

    assert property (@(posedge clk) disable iff (rst) flush_i |=> !wb_valid_i)
        else $error("wb valid right after a flush");

    assert property (@(posedge clk) disable iff (rst) refill_i |-> !req_valid_i)
        else $error("request issued during a refill");

endmodule

bind mem2_stage mem_pipe_props u_mem2_props (
    .clk            (clk),
    .rst            (rst),
    .flush_i        (flush_i),
    .data_ok_i      (data_ok_i),
    .req_valid_i    (1'b1),
    .refill_i       (1'b0),
    .load_pending_i (load_pending),
    .drain_i        (drain_q),
    .adv_ready_i    (advance_ready_o),
    .wb_valid_i     (wb_o.valid)
);

bind load_data_cache mem_pipe_props u_dcache_props (
    .clk            (clk),
    .rst            (rst),
    .flush_i        (1'b0),
    .data_ok_i      (data_ok_o),
    .req_valid_i    (req_i.valid),
    .refill_i       (state_q == mem_pipe_pkg::CACHE_REFILL),
    .load_pending_i (1'b0),
    .drain_i        (1'b0),
    .adv_ready_i    (1'b1),
    .wb_valid_i     (1'b0)
);

// File: mem_pipe_tb.sv
`include "mem_pipe_settings.svh"

module mem_pipe_tb;

    typedef struct packed {
        mem_pipe_pkg::mem_op_e op;
        logic [31:0]           base;
        logic [31:0]           offset;
        logic [31:0]           data;
        logic [4:0]            waddr;
        logic                  flush;
    } entry_t;

    logic                        clk;
    logic                        rst;
    logic                        flush_i;
    mem_pipe_pkg::exe_mem_t      exe_i;
    logic                        advance_o;
    mem_pipe_pkg::data_forward_t data_forward_o;
    mem_pipe_pkg::mem2_wb_t      wb_o;

    entry_t                      table_q[$];
    mem_pipe_pkg::mem2_wb_t      exp_q[$];
    int                          id_q[$];
    logic [7:0]                  ref_mem [4096];
    logic [31:0]                 lfsr_q;
    mem_pipe_pkg::data_forward_t prev_fwd;
    int                          errors;
    int                          checks;
    int                          cycles;
    int                          limit;
    logic                        started;
    logic                        draining;

    mem_pipe_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .exe_i          (exe_i),
        .advance_o      (advance_o),
        .data_forward_o (data_forward_o),
        .wb_o           (wb_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic add_entry(mem_pipe_pkg::mem_op_e op, logic [31:0] base,
                             logic [31:0] offset, logic [31:0] data, logic flush);
        entry_t e;
        e.op     = op;
        e.base   = base;
        e.offset = offset;
        e.data   = data;
        e.waddr  = 5'(rand_bits(5));
        e.flush  = flush;
        table_q.push_back(e);
    endtask

    function automatic mem_pipe_pkg::mem2_wb_t predict(entry_t e);
        mem_pipe_pkg::mem2_wb_t r;
        logic [11:0]            a;
        logic [7:0]             b;
        logic [15:0]            h;
        logic                   is_st;
        a = e.base[11:0] + e.offset[11:0];
        b = ref_mem[a];
        h = {ref_mem[a + 12'd1], ref_mem[a]};
        is_st = e.op inside {mem_pipe_pkg::OP_ST_B, mem_pipe_pkg::OP_ST_H,
                             mem_pipe_pkg::OP_ST_W};
        r.valid = 1'b1;
        r.wreg  = ~is_st;
        r.waddr = e.waddr;
        case (e.op)
            mem_pipe_pkg::OP_LD_B:  r.wdata = {{24{b[7]}}, b};
            mem_pipe_pkg::OP_LD_BU: r.wdata = {24'b0, b};
            mem_pipe_pkg::OP_LD_H:  r.wdata = a[0] ? 32'b0 : {{16{h[15]}}, h};
            mem_pipe_pkg::OP_LD_HU: r.wdata = a[0] ? 32'b0 : {16'b0, h};
            mem_pipe_pkg::OP_LD_W:  r.wdata = {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
            default:                r.wdata = e.data;
        endcase
        return r;
    endfunction

    task automatic model_store(entry_t e);
        logic [11:0] a;
        a = e.base[11:0] + e.offset[11:0];
        if (e.op == mem_pipe_pkg::OP_ST_B || e.op == mem_pipe_pkg::OP_ST_H ||
            e.op == mem_pipe_pkg::OP_ST_W) begin
            ref_mem[a] = e.data[7:0];
        end
        if (e.op == mem_pipe_pkg::OP_ST_H || e.op == mem_pipe_pkg::OP_ST_W) begin
            ref_mem[a + 12'd1] = e.data[15:8];
        end
        if (e.op == mem_pipe_pkg::OP_ST_W) begin
            ref_mem[a + 12'd2] = e.data[23:16];
            ref_mem[a + 12'd3] = e.data[31:24];
        end
    endtask

    task automatic check_wb(mem_pipe_pkg::mem2_wb_t exp, mem_pipe_pkg::mem2_wb_t got, int id);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t wb_o (test %0d) expected %h, got %h",
                     $time, id, exp, got);
        end else begin
            $display("test %0d ok: waddr %0d wdata %h", id, got.waddr, got.wdata);
        end
    endtask

    task automatic check_fwd(mem_pipe_pkg::data_forward_t exp, mem_pipe_pkg::data_forward_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t data_forward_o expected %h got %h", $time, exp, got);
        end
    endtask

    // results are sampled on the rising edge, before the registers update.
    always @(posedge clk) begin
        mem_pipe_pkg::data_forward_t fx;
        if (!rst) begin
            if (wb_o.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a result reached wb_o with no op expected at time %0t", $time);
                end else begin
                    fx = {exp_q[0].wreg, 1'b1, exp_q[0].waddr, exp_q[0].wdata};
                    check_fwd(fx, prev_fwd);
                    check_wb(exp_q.pop_front(), wb_o, id_q.pop_front());
                end
            end
            if (advance_o) begin
                started  <= 1'b1;
                draining <= 1'b0;
            end else if (started && !draining) begin
                // a held load shows nothing on the forwarding bus.
                check_fwd('0, data_forward_o);
            end
            if (flush_i) begin
                exp_q.delete();
                id_q.delete();
                draining <= 1'b1;
            end
            prev_fwd <= data_forward_o;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the pipeline stopped delivering results after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        entry_t      e;
        lfsr_q   = 32'h2b24621a;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        limit    = 0;
        started  = 1'b0;
        draining = 1'b0;
        prev_fwd = '0;
        rst      = 1'b1;
        flush_i  = 1'b0;
        exe_i    = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end

        // lane selection and extension at every byte offset.
        for (int r = 0; r < 4; r++) begin
            a = {20'b0, 10'(rand_bits(10)), 2'b00};
            add_entry(mem_pipe_pkg::OP_ST_W, a, 0, rand_bits(32), 1'b0);
            for (int off = 0; off < 4; off++) begin
                add_entry(mem_pipe_pkg::OP_LD_B, a, off, 0, 1'b0);
                add_entry(mem_pipe_pkg::OP_LD_BU, a, off, 0, 1'b0);
                add_entry(mem_pipe_pkg::OP_LD_H, a, off, 0, 1'b0);
                add_entry(mem_pipe_pkg::OP_LD_HU, a, off, 0, 1'b0);
            end
        end
        // partial stores merged into a word.
        for (int r = 0; r < 2; r++) begin
            a = {20'b0, 10'(rand_bits(10)), 2'b00};
            add_entry(mem_pipe_pkg::OP_ST_W, a, 0, rand_bits(32), 1'b0);
            add_entry(mem_pipe_pkg::OP_ST_B, a, 1, rand_bits(32), 1'b0);
            add_entry(mem_pipe_pkg::OP_ST_H, a, 2, rand_bits(32), 1'b0);
            add_entry(mem_pipe_pkg::OP_LD_W, a, 0, 0, 1'b0);
        end
        // loads within one line and across lines, mixed with ALU ops.
        a = {20'b0, 6'(rand_bits(6)), 6'b0};
        add_entry(mem_pipe_pkg::OP_ST_W, a, 8, rand_bits(32), 1'b0);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 0, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 8, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_ALU, 0, 0, rand_bits(32), 1'b0);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 4, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 16, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_ALU, 0, 0, rand_bits(32), 1'b0);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 8, 0, 1'b0);
        // flush with a miss and an ALU op in flight.
        add_entry(mem_pipe_pkg::OP_LD_W, a, 32, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_ALU, 0, 0, rand_bits(32), 1'b0);
        add_entry(mem_pipe_pkg::OP_ALU, 0, 0, 0, 1'b1);
        add_entry(mem_pipe_pkg::OP_LD_W, a, 8, 0, 1'b0);
        add_entry(mem_pipe_pkg::OP_ALU, 0, 0, rand_bits(32), 1'b0);
        limit = table_q.size() * (4 + `MEM_PIPE_MISS_CYCLES) + 50;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < table_q.size(); t++) begin
            @(negedge clk);
            e = table_q[t];
            if (e.flush) begin
                exe_i   = '0;
                flush_i = 1'b1;
                @(negedge clk);
                flush_i = 1'b0;
            end else begin
                exe_i.valid  = 1'b1;
                exe_i.op     = e.op;
                exe_i.wreg   = ~mem_pipe_pkg::op_is_store(e.op);
                exe_i.waddr  = e.waddr;
                exe_i.wdata  = e.data;
                exe_i.base   = e.base;
                exe_i.offset = e.offset;
                while (!advance_o) begin
                    @(negedge clk);
                end
                exp_q.push_back(predict(e));
                id_q.push_back(t);
                model_store(e);
                @(posedge clk);
            end
        end
        @(negedge clk);
        exe_i = '0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
mem_pipe_pkg.sv
mem1_stage.sv
load_data_cache.sv
mem2_stage.sv
mem_pipe_top.sv
mem_pipe_props.sv
mem_pipe_tb.sv

// File: Bender.yml
package:
  name: mem_pipe

export_include_dirs:
  - .

sources:
  - mem_pipe_pkg.sv
  - mem1_stage.sv
  - load_data_cache.sv
  - mem2_stage.sv
  - mem_pipe_top.sv
  - target: test
    files:
      - mem_pipe_props.sv
      - mem_pipe_tb.sv
